// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes of the load and store formats
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // funct3 field of loads and stores
    // stores only use the first three codes
    typedef enum logic [2:0] {
        f3_b  = 3'b000,
        f3_h  = 3'b001,
        f3_w  = 3'b010,
        f3_bu = 3'b100,
        f3_hu = 3'b101
    } funct3_e;

    // one memory operation per instruction
    // mem_none covers everything that does not touch memory
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_e;

    // field positions inside a 32-bit instruction word
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;
    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;

    // access sizes in bytes
    localparam int size_byte = 1;
    localparam int size_half = 2;
    localparam int size_word = 4;

endpackage

// ==== src/mem_stage_pkg.sv ====
package mem_stage_pkg;

    import rv_isa_pkg::*;

    // data and address width of the core
    localparam int xlen = 32;

    // default width of the status counters
    localparam int count_width = 16;

    // one memory request, formed by the decoder
    // op is already forced to mem_none on a fault
    typedef struct packed {
        mem_op_e         op;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            fault;
    } mem_req_t;

    // status seen from outside the stage
    // fault_addr holds the address of the latest misaligned access
    typedef struct packed {
        logic [count_width-1:0] load_count;
        logic [count_width-1:0] store_count;
        logic                   fault_seen;
        logic [xlen-1:0]        fault_addr;
    } mem_status_t;

    // number of byte lanes in one memory word
    localparam int lanes = xlen / 8;

    // request of an idle cycle
    localparam mem_req_t req_idle = '{
        op:    mem_none,
        addr:  '0,
        wdata: '0,
        fault: 1'b0
    };

endpackage

// ==== src/lsu_decode.sv ====
`timescale 1ns/10ps

module lsu_decode
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;
(
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [31:0]     rs1_value,
    input  logic [31:0]     rs2_value,
    output mem_req_t        req
);

    logic [6:0]      opcode;
    funct3_e         funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] addr;
    mem_op_e         op_dec;
    logic            misaligned;

    assign opcode = inst[opcode_msb:opcode_lsb];
    assign funct3 = funct3_e'(inst[funct3_msb:funct3_lsb]);

    // I-type for loads, S-type for stores
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        op_dec = mem_none;
        imm    = imm_i;
        if (inst_valid) begin
            if (opcode == opcode_load) begin
                case (funct3)
                    f3_b:    op_dec = mem_lb;
                    f3_h:    op_dec = mem_lh;
                    f3_w:    op_dec = mem_lw;
                    f3_bu:   op_dec = mem_lbu;
                    f3_hu:   op_dec = mem_lhu;
                    default: op_dec = mem_none;
                endcase
            end else if (opcode == opcode_store) begin
                imm = imm_s;
                case (funct3)
                    f3_b:    op_dec = mem_sb;
                    f3_h:    op_dec = mem_sh;
                    f3_w:    op_dec = mem_sw;
                    default: op_dec = mem_none;
                endcase
            end
        end
    end

    assign addr = rs1_value + imm;

    // half needs bit 0 clear, word needs bits 1:0 clear
    always_comb begin
        case (op_dec)
            mem_lh, mem_lhu, mem_sh: misaligned = addr[0];
            mem_lw, mem_sw:          misaligned = |addr[1:0];
            default:                 misaligned = 1'b0;
        endcase
    end

    // a faulting access keeps its address for the status block
    always_comb begin
        req.op    = misaligned ? mem_none : op_dec;
        req.addr  = addr;
        req.wdata = rs2_value;
        req.fault = misaligned;
    end

endmodule

// ==== src/data_mem.sv ====
`timescale 1ns/10ps

module data_mem
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    req,
    output logic [31:0] raw_word
);

    localparam int index_width = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [xlen-1:0]        mem [mem_words];
    logic [index_width-1:0] word_index;
    logic [lanes-1:0]       lane_en;
    logic [xlen-1:0]        lane_data;

    // upper address bits fold back onto the array
    assign word_index = index_width'(req.addr[xlen-1:2] % mem_words);

    assign raw_word = mem[word_index];

    // byte enables and replicated store data per access size
    always_comb begin
        lane_en   = '0;
        lane_data = req.wdata;
        case (req.op)
            mem_sb: begin
                lane_en   = lanes'(1) << req.addr[1:0];
                lane_data = {4{req.wdata[7:0]}};
            end
            mem_sh: begin
                lane_en   = req.addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{req.wdata[15:0]}};
            end
            mem_sw: begin
                lane_en   = '1;
                lane_data = req.wdata;
            end
            default: begin
                lane_en = '0;
            end
        endcase
    end

    // untouched lanes keep their old bytes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < mem_words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            for (int l = 0; l < lanes; l++) begin
                if (lane_en[l]) begin
                    mem[word_index][8*l +: 8] <= lane_data[8*l +: 8];
                end
            end
        end
    end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/10ps

module load_align
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;
(
    input  mem_req_t    req,
    input  logic [31:0] raw_word,
    output logic [31:0] load_data,
    output logic        load_valid
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte lane from address bits 1:0
    always_comb begin
        case (req.addr[1:0])
            2'd0:    byte_sel = raw_word[7:0];
            2'd1:    byte_sel = raw_word[15:8];
            2'd2:    byte_sel = raw_word[23:16];
            default: byte_sel = raw_word[31:24];
        endcase
    end

    // bit 0 is known clear for any half load that gets here
    assign half_sel = req.addr[1] ? raw_word[31:16] : raw_word[15:0];

    always_comb begin
        load_valid = 1'b1;
        case (req.op)
            mem_lb:  load_data = {{24{byte_sel[7]}}, byte_sel};
            mem_lh:  load_data = {{16{half_sel[15]}}, half_sel};
            mem_lw:  load_data = raw_word;
            mem_lbu: load_data = {24'b0, byte_sel};
            mem_lhu: load_data = {16'b0, half_sel};
            default: begin
                // stores and idle cycles return nothing
                load_data  = '0;
                load_valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/mem_status_regs.sv ====
`timescale 1ns/10ps

module mem_status_regs
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;
#(
    parameter int count_width = mem_stage_pkg::count_width
) (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    req,
    input  logic        clear_status,
    output mem_status_t status
);

    // width of the count fields in the status struct
    localparam int field_width = $bits(status.load_count);

    logic [count_width-1:0] load_cnt;
    logic [count_width-1:0] store_cnt;
    logic                   fault_seen;
    logic [xlen-1:0]        fault_addr;
    logic                   is_load;
    logic                   is_store;

    assign is_load  = req.op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
    assign is_store = req.op inside {mem_sb, mem_sh, mem_sw};

    // clear beats any update in the same cycle
    always_ff @(posedge clk) begin
        if (reset || clear_status) begin
            load_cnt   <= '0;
            store_cnt  <= '0;
            fault_seen <= 1'b0;
            fault_addr <= '0;
        end else begin
            if (is_load) begin
                load_cnt <= load_cnt + 1'b1;
            end
            if (is_store) begin
                store_cnt <= store_cnt + 1'b1;
            end
            // latest fault wins
            if (req.fault) begin
                fault_seen <= 1'b1;
                fault_addr <= req.addr;
            end
        end
    end

    always_comb begin
        status.load_count  = field_width'(load_cnt);
        status.store_count = field_width'(store_cnt);
        status.fault_seen  = fault_seen;
        status.fault_addr  = fault_addr;
    end

endmodule

// ==== src/mem_stage_top.sv ====
`timescale 1ns/10ps

module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int mem_words   = 256,
    parameter int count_width = mem_stage_pkg::count_width
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    input  logic        clear_status,
    output logic [31:0] load_data,
    output logic        load_valid,
    output logic        fault,
    output mem_status_t status
);

    mem_req_t    req;
    logic [31:0] raw_word;

    lsu_decode u_decode (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .req        (req)
    );

    data_mem #(
        .mem_words (mem_words)
    ) u_mem (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .raw_word (raw_word)
    );

    load_align u_align (
        .req        (req),
        .raw_word   (raw_word),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    mem_status_regs #(
        .count_width (count_width)
    ) u_status (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .clear_status (clear_status),
        .status       (status)
    );

    assign fault = req.fault;

endmodule

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// byte image of the data memory and the expected status
logic [7:0]             ref_bytes [4*mem_words];
logic [count_width-1:0] exp_loads;
logic [count_width-1:0] exp_stores;
logic                   exp_fault_seen;
logic [31:0]            exp_fault_addr;

// word index wraps at mem_words
function automatic int unsigned byte_slot(input logic [31:0] addr);
    return ((addr >> 2) % mem_words) * 4 + addr[1:0];
endfunction

// rd x5, rs1 x1
function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd5, opcode_load};
endfunction

// rs1 x1, rs2 x2
function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opcode_store};
endfunction

function automatic bit f3_defined(input int kind, input logic [2:0] f3);
    if (kind == kind_load) begin
        return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    end
    return kind == kind_store && f3 inside {3'b000, 3'b001, 3'b010};
endfunction

// funct3 bits 1:0 give the access size
function automatic bit misaligned_at(input logic [2:0] f3, input logic [31:0] addr);
    case (f3[1:0])
        2'd1:    return addr[0];
        2'd2:    return addr[1:0] != 2'd0;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] addr);
    int unsigned p;
    p = byte_slot(addr);
    case (f3)
        3'b000:  return {{24{ref_bytes[p][7]}}, ref_bytes[p]};
        3'b100:  return {24'h0, ref_bytes[p]};
        3'b001:  return {{16{ref_bytes[p+1][7]}}, ref_bytes[p+1], ref_bytes[p]};
        3'b101:  return {16'h0, ref_bytes[p+1], ref_bytes[p]};
        default: return {ref_bytes[p+3], ref_bytes[p+2], ref_bytes[p+1], ref_bytes[p]};
    endcase
endfunction

// what the clock edge at the end of an access changes
function automatic void commit_model(input int kind, input logic [2:0] f3,
                                     input logic [31:0] addr, input logic [31:0] data,
                                     input bit live, input bit flt, input bit clear);
    int unsigned p;
    p = byte_slot(addr);
    if (live && !flt && kind == kind_store) begin
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            ref_bytes[p+i] = data[8*i +: 8];
        end
    end
    if (clear) begin
        exp_loads      = '0;
        exp_stores     = '0;
        exp_fault_seen = 1'b0;
        exp_fault_addr = '0;
    end else if (live && flt) begin
        exp_fault_seen = 1'b1;
        exp_fault_addr = addr;
    end else if (live && kind == kind_load) begin
        exp_loads = exp_loads + 1'b1;
    end else if (live) begin
        exp_stores = exp_stores + 1'b1;
    end
endfunction

`endif

// ==== sim/tb_mem_stage.sv ====
`timescale 1ns/10ps

module tb_mem_stage
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;
();

    localparam int          clk_period = 4;
    localparam int          mem_words  = 256;
    localparam int          wait_limit = 8;
    localparam int          random_ops = 300;
    localparam logic [31:0] seed       = 32'h759d_9a7a;
    localparam int          kind_none  = 0;
    localparam int          kind_load  = 1;
    localparam int          kind_store = 2;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic        clear_status;
    logic [31:0] load_data;
    logic        load_valid;
    logic        fault;
    mem_status_t status;

    int          errors     = 0;
    int          timeouts   = 0;
    int          checks     = 0;
    int unsigned edge_count = 0;
    logic [2:0]  load_f3s [5] = '{f3_b, f3_h, f3_w, f3_bu, f3_hu};
    logic [2:0]  bad_f3s  [5] = '{f3_h, f3_hu, f3_w, f3_h, f3_w};

    `include "tb_ref_model.svh"

    mem_stage_top #(
        .mem_words   (mem_words),
        .count_width (count_width)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .clear_status (clear_status),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .fault        (fault),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_status();
        check_value("status.load_count", status.load_count, exp_loads);
        check_value("status.store_count", status.store_count, exp_stores);
        check_value("status.fault_seen", status.fault_seen, exp_fault_seen);
        check_value("status.fault_addr", status.fault_addr, exp_fault_addr);
    endtask

    // polls land 1 ns after an edge and never on one
    task automatic next_cycle(input int first_delay);
        int unsigned start;
        int          polls;
        start = edge_count;
        polls = 0;
        #(first_delay);
        while (edge_count == start && polls < wait_limit) begin
            #(clk_period);
            polls++;
        end
        if (edge_count == start) begin
            timeouts++;
            $display("timeout: no rising clock edge within %0d cycles", wait_limit);
        end
    endtask

    // one instruction per cycle with outputs sampled 1 ns before the edge
    task automatic issue(input logic valid, input logic [31:0] word, input int kind,
                         input logic [2:0] f3, input logic [31:0] addr,
                         input logic [31:0] rs1, input logic [31:0] rs2, input logic clear);
        bit          live;
        bit          flt;
        logic [31:0] exp_data;
        live     = valid && f3_defined(kind, f3);
        flt      = live && misaligned_at(f3, addr);
        exp_data = (live && !flt && kind == kind_load) ? expect_load(f3, addr) : 32'h0;
        inst_valid   = valid;
        inst         = word;
        rs1_value    = rs1;
        rs2_value    = rs2;
        clear_status = clear;
        #2;
        check_value("fault", fault, flt);
        check_value("load_valid", load_valid, live && !flt && kind == kind_load);
        check_value("load_data", load_data, exp_data);
        check_status();
        next_cycle(2);
        commit_model(kind, f3, addr, rs2, live, flt, clear);
    endtask

    task automatic mem_op(input int kind, input logic [2:0] f3, input logic [31:0] rs1,
                          input logic [11:0] imm, input logic [31:0] data, input logic clear);
        logic [31:0] word;
        word = (kind == kind_load) ? load_inst(f3, imm) : store_inst(f3, imm);
        issue(1'b1, word, kind, f3, rs1 + {{20{imm[11]}}, imm}, rs1, data, clear);
    endtask

    task automatic random_op(input logic clear);
        int         kind;
        logic [2:0] f3;
        kind = ($urandom % 2 == 0) ? kind_load : kind_store;
        f3   = (kind == kind_load) ? load_f3s[$urandom % 5] : 3'($urandom % 3);
        mem_op(kind, f3, $urandom % (16 * mem_words), 12'($urandom), $urandom, clear);
    endtask

    initial begin
        logic [31:0] base;
        logic [11:0] imm;
        logic [11:0] off;
        logic [2:0]  f3;
        void'($urandom(seed));
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        rs1_value    = '0;
        rs2_value    = '0;
        clear_status = 1'b0;
        for (int i = 0; i < 4 * mem_words; i++) begin
            ref_bytes[i] = 8'h0;
        end
        commit_model(kind_none, 3'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1);
        // reset held over three rising edges
        #3;
        next_cycle(clk_period);
        next_cycle(clk_period);
        reset = 1'b0;

        // cleared memory reads zero for every size
        for (int i = 0; i < 10; i++) begin
            f3 = load_f3s[$urandom % 5];
            mem_op(kind_load, f3, ($urandom % (16 * mem_words)) & ~32'h3,
                   12'($urandom) & 12'hffc, 32'h0, 1'b0);
        end

        // word written and then read through an alias
        for (int i = 0; i < 20; i++) begin
            base = ($urandom % (16 * mem_words)) & ~32'h3;
            imm  = 12'($urandom) & 12'hffc;
            mem_op(kind_store, f3_w, base, imm, $urandom, 1'b0);
            mem_op(kind_load, f3_w, base + 4 * mem_words * (1 + $urandom % 3), imm,
                   32'h0, 1'b0);
        end

        // byte and half lane stores read back with every load type
        for (int i = 0; i < 30; i++) begin
            base = ($urandom % (16 * mem_words)) & ~32'h3;
            imm  = 12'($urandom) & 12'hffc;
            f3   = 3'($urandom % 2);
            off  = 12'($urandom % 4) & 12'(4 - (1 << f3[1:0]));
            mem_op(kind_store, f3, base, imm | off, $urandom, 1'b0);
            for (int k = 0; k < 5; k++) begin
                off = 12'($urandom % 4) & 12'(4 - (1 << load_f3s[k][1:0]));
                mem_op(kind_load, load_f3s[k], base, imm | off, 32'h0, 1'b0);
            end
        end

        // LH LHU LW SH SW at odd offsets followed by an aligned word read
        for (int i = 0; i < 10; i++) begin
            base = ($urandom % (16 * mem_words)) & ~32'h3;
            imm  = 12'($urandom) & 12'hffc;
            f3   = bad_f3s[i % 5];
            off  = (f3[1:0] == 2'd1) ? 12'(1 + 2 * ($urandom % 2)) : 12'(1 + $urandom % 3);
            mem_op((i % 5 < 3) ? kind_load : kind_store, f3, base, imm | off, $urandom, 1'b0);
            mem_op(kind_load, f3_w, base, imm, 32'h0, 1'b0);
        end

        // clear wins over a load and over a fault
        mem_op(kind_load, f3_w, 32'h40, 12'h0, 32'h0, 1'b1);
        mem_op(kind_store, f3_w, 32'h41, 12'h0, 32'h1234_5678, 1'b0);
        mem_op(kind_load, f3_h, 32'h43, 12'h0, 32'h0, 1'b1);
        for (int i = 0; i < random_ops; i++) begin
            random_op(($urandom % 16) == 0);
        end

        // OP-IMM, undefined funct3 codes, store with inst_valid low
        issue(1'b1, {12'h123, 5'd1, 3'b000, 5'd3, 7'b0010011}, kind_none, 3'b000,
              32'h0, 32'h80, 32'h55, 1'b0);
        for (int f = 3; f < 8; f++) begin
            mem_op(kind_load, 3'(f), 32'h80, 12'h10, 32'h0, 1'b0);
            mem_op(kind_store, 3'(f), 32'h80, 12'h10, $urandom, 1'b0);
        end
        issue(1'b0, store_inst(f3_w, 12'h10), kind_store, f3_w, 32'h90, 32'h80,
              32'hdead_beef, 1'b0);
        mem_op(kind_load, f3_w, 32'h80, 12'h10, 32'h0, 1'b0);
        issue(1'b0, 32'h0, kind_none, 3'b000, 32'h0, 32'h0, 32'h0, 1'b0);

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage.f ====
+incdir+sim
src/rv_isa_pkg.sv
src/mem_stage_pkg.sv
src/lsu_decode.sv
src/data_mem.sv
src/load_align.sv
src/mem_status_regs.sv
src/mem_stage_top.sv
sim/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_stage -f mem_stage.f -o tb_mem_stage || exit 1

out=$(./obj_dir/tb_mem_stage)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && exit 0 || exit 1
